/* aes_pkg.sv */
/*
 * Shared constants and types for the AES SubBytes/ShiftRows stage.
 * State layout follows FIPS-197, with byte 0 in bits 127:120.
 * Byte index is 4*column + row, so a column is four adjacent bytes.
 * The packed state array is descending, so byte n sits at index 15-n.
 */
package aes_pkg;

	////////////////////////////////////////
	// State geometry
	////////////////////////////////////////

	// Full cipher state width in bits
	localparam int unsigned AES_STATE_W = 128;

	// Number of bytes in the state
	localparam int unsigned AES_NUM_BYTES = AES_STATE_W / 8;

	// Width of a byte index inside the state
	localparam int unsigned AES_IDX_W = $clog2(AES_NUM_BYTES);

	////////////////////////////////////////
	// Engine timing
	////////////////////////////////////////

	// Step counter width, holds idle (0) and steps 1..16
	localparam int unsigned AES_STEP_W = 5;

	// Rising edges from the accepted start edge to ready_o rising
	// One edge to leave idle, then one edge per byte
	localparam int unsigned AES_SUB_LATENCY = AES_NUM_BYTES + 1;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// One state byte
	typedef logic [7:0] aes_byte_t;

	// Whole state as packed bytes
	// Index 15 is byte 0 (most significant), index 0 is byte 15
	typedef aes_byte_t [AES_NUM_BYTES-1:0] aes_state_t;

endpackage

/* aes_sbox.sv */
/*
 * Combinational AES S-box with forward and inverse tables.
 * decrypt_i selects the inverse table.
 * No register inside, the caller issues and captures in one cycle.
 */
`timescale 1ns/1ns

module aes_sbox
	import aes_pkg::*;
(
	input  aes_byte_t data_i,
	input  logic      decrypt_i,
	output aes_byte_t data_o
);

	////////////////////////////////////////
	// Forward table, SubBytes
	////////////////////////////////////////

	// Row n holds entries 8n to 8n+7
	localparam aes_byte_t FWD_TABLE [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	////////////////////////////////////////
	// Inverse table, InvSubBytes
	////////////////////////////////////////

	// Exact inverse of the forward map above
	localparam aes_byte_t INV_TABLE [256] = '{
		8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
		8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
		8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
		8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
		8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
		8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
		8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
		8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
		8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
		8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
		8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
		8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
		8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
		8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
		8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
		8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
		8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
		8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
		8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
		8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
		8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
		8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
		8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
		8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
		8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
		8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
		8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
		8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
		8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
		8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
		8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
		8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
	};

	// Plain table lookup, direction picks the table
	assign data_o = decrypt_i ? INV_TABLE[data_i] : FWD_TABLE[data_i];

endmodule

/* subbytes.sv */
/*
 * Byte-serial SubBytes + ShiftRows (or inverse) over one shared S-box.
 * start_i is sampled only while idle; a start while busy is dropped.
 * data_i and decrypt_i must stay stable until ready_o.
 * ready_o pulses one cycle, 17 edges after the start edge.
 * data_o holds the result until the next run starts writing bytes.
 */
`timescale 1ns/1ns

module subbytes
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start_i,
	input  logic       decrypt_i,
	input  aes_state_t data_i,
	output logic       ready_o,
	output aes_state_t data_o,
	output aes_byte_t  sbox_data_o,
	input  aes_byte_t  sbox_data_i,
	output logic       sbox_decrypt_o
);

	// Step counter, 0 is idle, 1..16 walk the bytes
	logic [AES_STEP_W-1:0] step_q;
	logic [AES_STEP_W-1:0] step_d;
	// Byte handled in the current step
	logic [AES_IDX_W-1:0]  byte_idx;
	logic                  busy;
	logic                  last_step;
	// Working state and its next value
	aes_state_t            work_q;
	aes_state_t            work_d;
	// Working state with the current byte already substituted
	aes_state_t            merged;
	logic                  ready_d;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// FIPS byte number to packed array index
	function automatic int unsigned byte_pos(input int unsigned idx);
		return AES_NUM_BYTES - 1 - idx;
	endfunction

	// Row r rotates left by r columns, or right when inverse
	function automatic aes_state_t shift_rows(input aes_state_t s, input logic inv);
		aes_state_t  r;
		int unsigned src_col;
		r = s;
		for (int unsigned col = 0; col < 4; col++)
		begin
			for (int unsigned row = 0; row < 4; row++)
			begin
				// Source column for this output position
				if (inv)
					src_col = (col + 4 - row) % 4;
				else
					src_col = (col + row) % 4;
				r[byte_pos(4 * col + row)] = s[byte_pos(4 * src_col + row)];
			end
		end
		return r;
	endfunction

	////////////////////////////////////////
	// Step decode and S-box drive
	////////////////////////////////////////

	assign busy      = (step_q != '0);
	assign last_step = (step_q == AES_STEP_W'(AES_NUM_BYTES));

	// Step s handles byte s-1
	// In idle this wraps to byte 15, harmless since nothing is written
	assign byte_idx = AES_IDX_W'(step_q - 1'b1);

	// S-box is combinational, its answer is back in the same cycle
	assign sbox_data_o    = data_i[byte_pos(byte_idx)];
	assign sbox_decrypt_o = decrypt_i;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb
	begin
		merged = work_q;
		merged[byte_pos(byte_idx)] = sbox_data_i;

		step_d  = step_q;
		work_d  = work_q;
		ready_d = 1'b0;

		if (!busy)
		begin
			// Idle, wait for start, keep last result visible
			if (start_i)
				step_d = AES_STEP_W'(1);
		end
		else if (last_step)
		begin
			// Last byte in, then the row permutation in the same edge
			work_d  = shift_rows(merged, decrypt_i);
			ready_d = 1'b1;
			step_d  = '0;
		end
		else
		begin
			work_d = merged;
			step_d = step_q + 1'b1;
		end
	end

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			step_q  <= '0;
			work_q  <= '0;
			ready_o <= 1'b0;
		end
		else
		begin
			step_q  <= step_d;
			work_q  <= work_d;
			ready_o <= ready_d;
		end
	end

	assign data_o = work_q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Ready is a single-cycle pulse, also across back-to-back runs
	a_ready_pulse: assert property (@(posedge clk) disable iff (!reset)
		ready_o |=> !ready_o)
		else $error("ready_o high for two cycles");

	// Counter stays within idle and the 16 byte steps
	a_step_range: assert property (@(posedge clk) disable iff (!reset)
		step_q <= AES_STEP_W'(AES_NUM_BYTES))
		else $error("step counter out of range");

	// First busy step to ready rising spans the rest of the latency
	a_latency: assert property (@(posedge clk) disable iff (!reset)
		(step_q == AES_STEP_W'(1)) |-> ##(AES_SUB_LATENCY - 1) $rose(ready_o))
		else $error("ready_o latency mismatch");

endmodule

/* aes_subshift_top.sv */
/*
 * Top of the SubBytes/ShiftRows stage.
 * Stepping engine plus one combinational S-box, no extra cycles.
 * reset is asynchronous, active low.
 * Hold data_i and decrypt_i stable from the start until ready_o.
 */
`timescale 1ns/1ns

module aes_subshift_top
	import aes_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start_i,
	input  logic                   decrypt_i,
	input  logic [AES_STATE_W-1:0] data_i,
	output logic                   ready_o,
	output logic [AES_STATE_W-1:0] data_o
);

	////////////////////////////////////////
	// S-box link
	////////////////////////////////////////

	// Byte going into the S-box
	aes_byte_t sbox_in;
	// Substituted byte coming back
	aes_byte_t sbox_out;
	// Table select, follows decrypt_i
	logic      sbox_decrypt;

	// Byte stepping engine
	subbytes sub_i (
		.clk            (clk),
		.reset          (reset),
		.start_i        (start_i),
		.decrypt_i      (decrypt_i),
		.data_i         (data_i),
		.ready_o        (ready_o),
		.data_o         (data_o),
		.sbox_data_o    (sbox_in),
		.sbox_data_i    (sbox_out),
		.sbox_decrypt_o (sbox_decrypt)
	);

	// Shared forward/inverse S-box
	aes_sbox sbox_i (
		.data_i    (sbox_in),
		.decrypt_i (sbox_decrypt),
		.data_o    (sbox_out)
	);

endmodule

/* tb_aes_model.svh */
/*
 * Reference model for the SubBytes/ShiftRows testbench.
 * S-box built from GF(2^8) inversion (poly 0x11B) plus the affine map.
 * Call build_model_tables once before expected_result.
 * Byte n of a state sits in bits 127-8n down to 120-8n.
 */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Filled by build_model_tables
logic [7:0] model_fwd [256];
logic [7:0] model_inv [256];

// Shift-and-add product, reduced by x^8+x^4+x^3+x+1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	logic [7:0] y;
	p = 8'h00;
	x = a;
	y = b;
	for (int i = 0; i < 8; i++)
	begin
		if (y[0])
			p = p ^ x;
		// Times x, fold the carry back in
		if (x[7])
			x = (x << 1) ^ 8'h1b;
		else
			x = x << 1;
		y = y >> 1;
	end
	return p;
endfunction

// Multiplicative inverse by search, zero maps to zero
function automatic logic [7:0] gf_inv(input logic [7:0] a);
	for (int b = 1; b < 256; b++)
	begin
		if (gf_mul(a, 8'(b)) == 8'h01)
			return 8'(b);
	end
	return 8'h00;
endfunction

// b_i = x_i ^ x_i+4 ^ x_i+5 ^ x_i+6 ^ x_i+7 ^ c_i, with c = 0x63
function automatic logic [7:0] affine(input logic [7:0] x);
	return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]}
		^ {x[3:0], x[7:4]} ^ 8'h63;
endfunction

task automatic build_model_tables();
	for (int v = 0; v < 256; v++)
		model_fwd[v] = affine(gf_inv(8'(v)));
	// Inverse entry y is the input that the forward map sends to y
	for (int y = 0; y < 256; y++)
	begin
		for (int x = 0; x < 256; x++)
		begin
			if (model_fwd[x] == 8'(y))
				model_inv[y] = 8'(x);
		end
	end
endtask

// Substitution and row shift in one pass, order does not matter
function automatic logic [127:0] expected_result(input logic [127:0] s, input logic inv);
	logic [127:0] r;
	int           src;
	for (int n = 0; n < 16; n++)
	begin
		// Row n%4 rotates left by its row number, right when inverse
		if (inv)
			src = 4 * ((n / 4 + 4 - n % 4) % 4) + n % 4;
		else
			src = 4 * ((n / 4 + n % 4) % 4) + n % 4;
		if (inv)
			r[127 - 8 * n -: 8] = model_inv[s[127 - 8 * src -: 8]];
		else
			r[127 - 8 * n -: 8] = model_fwd[s[127 - 8 * src -: 8]];
	end
	return r;
endfunction

`endif

/* tb_aes_subshift.sv */
/*
 * Testbench for the SubBytes/ShiftRows stage.
 * Expected values come from the field-arithmetic model header.
 * The run stops at the first mismatch.
 * A watchdog bounds the run time.
 */
`timescale 1ns/1ns

module tb_aes_subshift
	import aes_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 16;
	localparam int NUM_B2B      = 6;
	localparam int IDLE_WINDOW  = 20;
	localparam int WAIT_LIMIT   = 2 * AES_SUB_LATENCY + 6;
	// Operations in the known pair, the random pairs, the busy run and the back-to-back runs
	localparam int NUM_OPS      = 3 + 2 * NUM_RANDOM + NUM_B2B;
	localparam int WATCHDOG_NS  = (NUM_OPS * 20 + RESET_CYCLES + IDLE_WINDOW + 50) * CLK_PERIOD;

	// FIPS-197 round 1 state before and after SubBytes and ShiftRows
	localparam logic [AES_STATE_W-1:0] KNOWN_IN  = 128'h193de3bea0f4e22b9ac68d2ae9f84808;
	localparam logic [AES_STATE_W-1:0] KNOWN_OUT = 128'hd4bf5d30e0b452aeb84111f11e2798e5;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   start_i;
	logic                   decrypt_i;
	logic [AES_STATE_W-1:0] data_i;
	logic                   ready_o;
	logic [AES_STATE_W-1:0] data_o;
	integer                 seed = 32'hfa77_b817;

	`include "tb_aes_model.svh"

	aes_subshift_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.start_i   (start_i),
		.decrypt_i (decrypt_i),
		.data_i    (data_i),
		.ready_o   (ready_o),
		.data_o    (data_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Reporting and helpers
	////////////////////////////////////////

	task automatic fail_value(input string name, input logic [AES_STATE_W-1:0] expected,
		input logic [AES_STATE_W-1:0] actual);
		$display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		$display("Testbench failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic fail_text(input string what);
		$display("Error at t=%0t: %s", $time, what);
		$display("Testbench failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_state(input string name, input logic [AES_STATE_W-1:0] expected,
		input logic [AES_STATE_W-1:0] actual);
		assert (actual === expected)
		else fail_value(name, expected, actual);
	endtask

	// Outputs are settled 1 ns after the edge and inputs change there too
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic random_state(output logic [AES_STATE_W-1:0] s);
		s = {$random(seed), $random(seed), $random(seed), $random(seed)};
	endtask

	// Count edges from the start edge up to ready_o
	// hold keeps start_i high and poke pulses it while the engine is busy
	task automatic wait_ready(input logic hold, input logic poke, output int edges);
		edges = 0;
		do
		begin
			next_cycle();
			edges++;
			start_i = hold || (poke && (edges % 4 == 0) && (edges < AES_NUM_BYTES));
		end
		while (!ready_o && edges < WAIT_LIMIT);
		if (!ready_o)
			fail_text("ready_o did not rise within the wait limit");
		assert (edges == AES_SUB_LATENCY)
		else fail_value("ready_o latency", AES_STATE_W'(AES_SUB_LATENCY), AES_STATE_W'(edges));
	endtask

	// One operation with its result checked at ready_o
	task automatic run_op(input logic [AES_STATE_W-1:0] state, input logic dec,
		input logic poke, input logic [AES_STATE_W-1:0] expected,
		output logic [AES_STATE_W-1:0] result);
		int edges;
		data_i    = state;
		decrypt_i = dec;
		start_i   = 1'b1;
		wait_ready(1'b0, poke, edges);
		result = data_o;
		check_state("data_o", expected, data_o);
	endtask

	////////////////////////////////////////
	// Concurrent checks
	////////////////////////////////////////

	a_reset_ready: assert property (@(posedge clk) !reset |-> !ready_o)
		else fail_value("ready_o", '0, AES_STATE_W'($sampled(ready_o)));

	a_reset_data: assert property (@(posedge clk) !reset |-> data_o == '0)
		else fail_value("data_o", '0, $sampled(data_o));

	a_ready_single: assert property (@(posedge clk) disable iff (!reset) ready_o |=> !ready_o)
		else fail_text("ready_o stayed high for two cycles");

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		logic [AES_STATE_W-1:0] state;
		logic [AES_STATE_W-1:0] result;
		logic [31:0]            coin;
		logic                   dir;
		logic [AES_STATE_W-1:0] b2b_state [NUM_B2B];
		logic                   b2b_dir [NUM_B2B];
		int                     edges;

		reset     = 1'b0;
		start_i   = 1'b0;
		decrypt_i = 1'b0;
		data_i    = '0;
		build_model_tables();
		// Model itself has to reproduce the FIPS vector
		check_state("model known vector", KNOWN_OUT, expected_result(KNOWN_IN, 1'b0));

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b1;
		// Quiet after release until the first start
		repeat (3)
		begin
			check_state("ready_o", '0, AES_STATE_W'(ready_o));
			check_state("data_o", '0, data_o);
			next_cycle();
		end

		// Known vector forward and then back through the inverse
		run_op(KNOWN_IN, 1'b0, 1'b0, KNOWN_OUT, result);
		run_op(result, 1'b1, 1'b0, KNOWN_IN, result);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			random_state(state);
			coin = $random(seed);
			dir  = coin[0];
			// Random direction checked against the model
			run_op(state, dir, 1'b0, expected_result(state, dir), result);
			// The opposite direction restores the original state
			run_op(result, !dir, 1'b0, state, result);
		end

		// Starts while busy are dropped and only one ready pulse follows
		random_state(state);
		run_op(state, 1'b0, 1'b1, expected_result(state, 1'b0), result);
		repeat (IDLE_WINDOW)
		begin
			next_cycle();
			assert (!ready_o)
			else fail_text("extra ready_o pulse after starts while busy");
		end

		// start_i stays high and the next inputs load in each ready cycle
		for (int k = 0; k < NUM_B2B; k++)
		begin
			random_state(b2b_state[k]);
			coin       = $random(seed);
			b2b_dir[k] = coin[0];
		end
		data_i    = b2b_state[0];
		decrypt_i = b2b_dir[0];
		start_i   = 1'b1;
		for (int k = 0; k < NUM_B2B; k++)
		begin
			wait_ready(1'b1, 1'b0, edges);
			check_state("data_o back-to-back", expected_result(b2b_state[k], b2b_dir[k]),
				data_o);
			if (k + 1 < NUM_B2B)
			begin
				data_i    = b2b_state[k + 1];
				decrypt_i = b2b_dir[k + 1];
			end
			else
				start_i = 1'b0;
		end

		repeat (2) next_cycle();
		$display("Testbench passed");
		$finish;
	end

	// Watchdog sized from the number of operations
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* tb.f */
+incdir+.
aes_pkg.sv
aes_sbox.sv
subbytes.sv
aes_subshift_top.sv
tb_aes_subshift.sv

/* Makefile */
# Verilator build and run for the SubBytes/ShiftRows stage
VERILATOR ?= verilator
TOP       := tb_aes_subshift
RTL_TOP   := aes_subshift_top
FILELIST  := tb.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing

SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run build lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# Exit status of the simulation is the pass or fail result
run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
